/* src/pulse_gen_pkg.sv */
// Shared widths and the configuration field selector for the pulse generator bank
// Imported by every RTL block and by the testbench
`default_nettype none

package pulse_gen_pkg;

  // ************************************************************************
  // Widths
  // ************************************************************************

  // Period, width and counter values all fit in one 32 bit word
  localparam int cnt_width = 32;

  // Width of each saturating edge counter in the output collector
  localparam int count_width = 16;

  // ************************************************************************
  // Configuration write targets
  // ************************************************************************

  // Selects what a configuration write lands in
  // The channel index is ignored for the enable mask
  typedef enum logic [1:0] {
    field_period = 2'd0,
    field_width  = 2'd1,
    field_enable = 2'd2
  } cfg_field_e;

endpackage

`default_nettype wire

/* src/pulse_cfg_regs.sv */
// Shadow and active configuration registers for every pulse channel
// Writes land in the shadow set, a commit copies it to the active set and restarts all channels
`timescale 1ns/1ps
`default_nettype none

module pulse_cfg_regs #(
  parameter int n_channels = 4,
  parameter int default_width = 7,
  localparam int chan_width = (n_channels > 1) ? $clog2(n_channels) : 1
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                cfg_wr,
  input  pulse_gen_pkg::cfg_field_e           cfg_field,
  input  logic [chan_width-1:0]               cfg_chan,
  input  logic [pulse_gen_pkg::cnt_width-1:0] cfg_data,
  input  logic                                cfg_commit,
  output logic [pulse_gen_pkg::cnt_width-1:0] period [n_channels],
  output logic [n_channels-1:0]               period_en,
  output logic [pulse_gen_pkg::cnt_width-1:0] width [n_channels],
  output logic [n_channels-1:0]               ch_en,
  output logic                                restart
);

  import pulse_gen_pkg::*;

  // Shadow copies, written by the configuration strobe
  logic [cnt_width-1:0]  sh_period [n_channels];
  logic [cnt_width-1:0]  sh_width [n_channels];
  logic [n_channels-1:0] sh_written;
  logic [n_channels-1:0] sh_en;

  // Decoded write strobes
  logic wr_period;
  logic wr_width;
  logic wr_enable;

  assign wr_period = cfg_wr && (cfg_field == field_period);
  assign wr_width  = cfg_wr && (cfg_field == field_width);
  assign wr_enable = cfg_wr && (cfg_field == field_enable);

  // ************************************************************************
  // Period registers
  // ************************************************************************

  // Periods are plain payload, validity is tracked by the written flags below
  always_ff @(posedge clk) begin
    for (int i = 0; i < n_channels; i++) begin
      if (wr_period && (int'(cfg_chan) == i)) begin
        sh_period[i] <= cfg_data;
      end
      // A commit samples the shadow as it was before any write on the same edge
      if (cfg_commit) begin
        period[i] <= sh_period[i];
      end
    end
  end

  // ************************************************************************
  // Width, written flags, enable mask and restart
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sh_written <= '0;
      sh_en      <= '0;
      period_en  <= '0;
      ch_en      <= '0;
      restart    <= 1'b0;
      for (int i = 0; i < n_channels; i++) begin
        sh_width[i] <= cnt_width'(default_width);
        width[i]    <= cnt_width'(default_width);
      end
    end else begin
      for (int i = 0; i < n_channels; i++) begin
        if (wr_width && (int'(cfg_chan) == i)) begin
          sh_width[i] <= cfg_data;
        end
        // The flag stays set until reset, a period once written is kept
        if (wr_period && (int'(cfg_chan) == i)) begin
          sh_written[i] <= 1'b1;
        end
        if (cfg_commit) begin
          width[i] <= sh_width[i];
        end
      end
      if (wr_enable) begin
        sh_en <= cfg_data[n_channels-1:0];
      end
      if (cfg_commit) begin
        period_en <= sh_written;
        ch_en     <= sh_en;
      end
      // Restart follows the commit by one cycle so every channel sees the new set together
      restart <= cfg_commit;
    end
  end

  // Channel writes must address an existing channel or they are silently dropped
  chan_in_range_a: assert property (@(posedge clk) disable iff (!rstn)
    (wr_period || wr_width) |-> (int'(cfg_chan) < n_channels));

endmodule

`default_nettype wire

/* src/pulse_channel.sv */
// One periodic pulse generator with a default-period fallback
// Each period starts with a pulse of the programmed width, restart realigns the phase
`timescale 1ns/1ps
`default_nettype none

module pulse_channel #(
  parameter int default_period = 100
) (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic [pulse_gen_pkg::cnt_width-1:0] period,
  input  logic                                period_en,
  input  logic [pulse_gen_pkg::cnt_width-1:0] width,
  input  logic                                ch_en,
  input  logic                                restart,
  output logic                                pulse
);

  import pulse_gen_pkg::*;

  // Effective period and width, sampled every cycle
  logic [cnt_width-1:0] period_d;
  logic [cnt_width-1:0] width_d;

  // Free-running period counter and the count of high cycles so far
  logic [cnt_width-1:0] period_cnt;
  logic [cnt_width-1:0] width_cnt;

  logic end_of_period;
  logic start_of_period;

  // ************************************************************************
  // Effective settings
  // ************************************************************************

  // Fall back to the default period until software has programmed one
  always_ff @(posedge clk) begin
    period_d <= period_en ? period : cnt_width'(default_period);
    width_d  <= width;
  end

  // ************************************************************************
  // Period counter
  // ************************************************************************

  // Compare with >= so a counter past a shortened period still wraps
  assign end_of_period   = (period_cnt >= (period_d - 1'b1));
  assign start_of_period = (period_cnt == '0);

  always_ff @(posedge clk) begin
    if (!rstn || restart || !ch_en) begin
      period_cnt <= '0;
    end else if (end_of_period) begin
      period_cnt <= '0;
    end else begin
      period_cnt <= period_cnt + 1'b1;
    end
  end

  // ************************************************************************
  // Pulse width counter
  // ************************************************************************

  // The pulse rises in the cycle after the counter held zero
  // It stays high for width_d cycles, then drops until the next wrap
  always_ff @(posedge clk) begin
    if (!rstn || restart || !ch_en) begin
      pulse     <= 1'b0;
      width_cnt <= '0;
    end else if (start_of_period) begin
      pulse     <= 1'b1;
      width_cnt <= cnt_width'(1);
    end else if (pulse) begin
      if (width_cnt >= width_d) begin
        pulse <= 1'b0;
      end else begin
        width_cnt <= width_cnt + 1'b1;
      end
    end
  end

  // The settings reach period_d one cycle after the commit, during restart
  // From then on a running channel needs a pulse that fits inside its period
  width_fits_a: assert property (@(posedge clk) disable iff (!rstn)
    (ch_en && !restart) |-> ((width_d >= 1) && (width_d < period_d)));

endmodule

`default_nettype wire

/* src/pulse_collector.sv */
// Output stage of the pulse generator bank
// Registers the pulse vector, flags any active pulse and counts rising edges per channel
`timescale 1ns/1ps
`default_nettype none

module pulse_collector #(
  parameter int n_channels = 4,
  localparam int chan_width = (n_channels > 1) ? $clog2(n_channels) : 1
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic [n_channels-1:0]                 pulse_in,
  input  logic                                  cnt_clr,
  input  logic [chan_width-1:0]                 rd_chan,
  output logic [n_channels-1:0]                 pulse_out,
  output logic                                  pulse_any,
  output logic [pulse_gen_pkg::count_width-1:0] rd_count
);

  import pulse_gen_pkg::*;

  // Previous output bits for edge detection
  logic [n_channels-1:0]  pulse_out_d;
  logic [n_channels-1:0]  pulse_rise;

  // One saturating edge counter per channel
  logic [count_width-1:0] edge_cnt [n_channels];

  // ************************************************************************
  // Output register stage
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pulse_out   <= '0;
      pulse_out_d <= '0;
    end else begin
      pulse_out   <= pulse_in;
      pulse_out_d <= pulse_out;
    end
  end

  // Follows the registered bits, so it lines up with pulse_out
  assign pulse_any  = |pulse_out;
  assign pulse_rise = pulse_out & ~pulse_out_d;

  // ************************************************************************
  // Edge counters
  // ************************************************************************

  // Clear wins over a rising edge on the same cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < n_channels; i++) begin
        edge_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < n_channels; i++) begin
        if (cnt_clr) begin
          edge_cnt[i] <= '0;
        end else if (pulse_rise[i] && (edge_cnt[i] != '1)) begin
          edge_cnt[i] <= edge_cnt[i] + 1'b1;
        end
      end
    end
  end

  // Readback mux, an unused select reads as zero
  assign rd_count = (int'(rd_chan) < n_channels) ? edge_cnt[rd_chan] : '0;

  rd_chan_in_range_a: assert property (@(posedge clk) disable iff (!rstn)
    int'(rd_chan) < n_channels);

endmodule

`default_nettype wire

/* src/pulse_gen_bank.sv */
// Top level of the programmable pulse generator bank
// Ties the configuration registers, one generator per channel and the output collector
`timescale 1ns/1ps
`default_nettype none

module pulse_gen_bank #(
  parameter int n_channels = 4,
  parameter int default_period = 100,
  parameter int default_width = 7,
  localparam int chan_width = (n_channels > 1) ? $clog2(n_channels) : 1
) (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  cfg_wr,
  input  pulse_gen_pkg::cfg_field_e             cfg_field,
  input  logic [chan_width-1:0]                 cfg_chan,
  input  logic [pulse_gen_pkg::cnt_width-1:0]   cfg_data,
  input  logic                                  cfg_commit,
  input  logic                                  cnt_clr,
  input  logic [chan_width-1:0]                 rd_chan,
  output logic [n_channels-1:0]                 pulse_out,
  output logic                                  pulse_any,
  output logic [pulse_gen_pkg::count_width-1:0] rd_count
);

  import pulse_gen_pkg::*;

  // Active settings fanned out to the channels
  logic [cnt_width-1:0]  period [n_channels];
  logic [cnt_width-1:0]  width [n_channels];
  logic [n_channels-1:0] period_en;
  logic [n_channels-1:0] ch_en;
  logic                  restart;

  // Raw channel pulses before the output register
  logic [n_channels-1:0] pulse_ch;

  pulse_cfg_regs #(
    .n_channels    (n_channels),
    .default_width (default_width)
  ) pulse_cfg_regs_inst (
    .clk        (clk),
    .rstn       (rstn),
    .cfg_wr     (cfg_wr),
    .cfg_field  (cfg_field),
    .cfg_chan   (cfg_chan),
    .cfg_data   (cfg_data),
    .cfg_commit (cfg_commit),
    .period     (period),
    .period_en  (period_en),
    .width      (width),
    .ch_en      (ch_en),
    .restart    (restart)
  );

  // All channels share the restart strobe, which keeps them phase aligned
  for (genvar i = 0; i < n_channels; i++) begin : gen_channel
    pulse_channel #(
      .default_period (default_period)
    ) pulse_channel_inst (
      .clk       (clk),
      .rstn      (rstn),
      .period    (period[i]),
      .period_en (period_en[i]),
      .width     (width[i]),
      .ch_en     (ch_en[i]),
      .restart   (restart),
      .pulse     (pulse_ch[i])
    );
  end

  pulse_collector #(
    .n_channels (n_channels)
  ) pulse_collector_inst (
    .clk       (clk),
    .rstn      (rstn),
    .pulse_in  (pulse_ch),
    .cnt_clr   (cnt_clr),
    .rd_chan   (rd_chan),
    .pulse_out (pulse_out),
    .pulse_any (pulse_any),
    .rd_count  (rd_count)
  );

endmodule

`default_nettype wire

/* test/tb_pulse_gen_bank.sv */
// Self-checking testbench for the pulse generator bank
// Applies a table of channel settings row by row and checks pulse timing, pulse_any and rd_count
`timescale 1ns/1ps
`default_nettype none

module tb_pulse_gen_bank;

  import pulse_gen_pkg::*;

  localparam int n_ch = 4;
  localparam int def_period = 100;
  localparam int def_width = 7;
  localparam int n_rows = 7;
  localparam int window_len = 400;
  localparam int idle_len = 20;
  localparam int timeout_cycles = n_rows * 420 + 200;

  logic                   clk;
  logic                   rstn;
  logic                   cfg_wr;
  cfg_field_e             cfg_field;
  logic [1:0]             cfg_chan;
  logic [cnt_width-1:0]   cfg_data;
  logic                   cfg_commit;
  logic                   cnt_clr;
  logic [1:0]             rd_chan;
  logic [n_ch-1:0]        pulse_out;
  logic                   pulse_any;
  logic [count_width-1:0] rd_count;

  // Stimulus table, one row per commit
  int              tbl_p [n_rows][n_ch];
  int              tbl_w [n_rows][n_ch];
  logic [n_ch-1:0] tbl_wr [n_rows];
  logic [n_ch-1:0] tbl_en [n_rows];
  integer          seed;

  // Expected shadow and active settings, derived from the writes and commits
  int              sh_p [n_ch];
  int              sh_w [n_ch];
  logic [n_ch-1:0] sh_written;
  int              act_p [n_ch];
  int              act_w [n_ch];
  logic [n_ch-1:0] act_en;

  // Pulse monitor state
  int              cyc;
  int              since_arm;
  int              holdoff;
  int              align_cyc;
  logic            committed;
  logic [n_ch-1:0] armed;
  logic [n_ch-1:0] prev_out;
  logic [n_ch-1:0] rise_now;
  logic [n_ch-1:0] in_run;
  logic [n_ch-1:0] have_rise;
  int              run_len [n_ch];
  int              last_rise [n_ch];
  int              edge_seen [n_ch];
  int              timeout_cnt;

  pulse_gen_bank #(
    .n_channels     (n_ch),
    .default_period (def_period),
    .default_width  (def_width)
  ) pulse_gen_bank_inst (
    .clk        (clk),
    .rstn       (rstn),
    .cfg_wr     (cfg_wr),
    .cfg_field  (cfg_field),
    .cfg_chan   (cfg_chan),
    .cfg_data   (cfg_data),
    .cfg_commit (cfg_commit),
    .cnt_clr    (cnt_clr),
    .rd_chan    (rd_chan),
    .pulse_out  (pulse_out),
    .pulse_any  (pulse_any),
    .rd_count   (rd_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ************************************************************************
  // Checking and timeout
  // ************************************************************************

  task automatic check_value(input string name, input logic [31:0] observed,
                             input logic [31:0] expected);
    if (observed !== expected) begin
      $display("[FAIL] %0t ns %s observed %0d expected %0d", $time, name, observed, expected);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  always @(posedge clk) begin
    timeout_cnt = timeout_cnt + 1;
    if (timeout_cnt > timeout_cycles) begin
      $display("The run did not finish within %0d clock cycles", timeout_cycles);
      $display("TEST FAIL");
      $fatal(1, "timeout");
    end
  end

  // ************************************************************************
  // Stimulus table
  // ************************************************************************

  task automatic fill_table();
    for (int r = 0; r < n_rows; r++) begin
      for (int i = 0; i < n_ch; i++) begin
        tbl_p[r][i] = 0;
        tbl_w[r][i] = 0;
      end
    end
    // Nothing programmed, every channel runs on the defaults
    tbl_wr[0] = 4'b0000;
    tbl_en[0] = 4'b1111;
    // Channels 1 and 3 still have no period, channel 3 is off
    tbl_wr[1] = 4'b0101;
    tbl_en[1] = 4'b0111;
    tbl_p[1][0] = 10;
    tbl_w[1][0] = 3;
    tbl_p[1][2] = 25;
    tbl_w[1][2] = 1;
    // Corner widths and the shortest legal period
    tbl_wr[2] = 4'b1111;
    tbl_en[2] = 4'b1010;
    tbl_p[2] = '{4, 2, 40, 17};
    tbl_w[2] = '{3, 1, 20, 16};
    for (int r = 3; r < 6; r++) begin
      tbl_wr[r] = 4'b1111;
      tbl_en[r] = 4'($random(seed)) | 4'b0001;
      for (int i = 0; i < n_ch; i++) begin
        tbl_p[r][i] = 4 + ({$random(seed)} % 37);
        tbl_w[r][i] = 1 + ({$random(seed)} % (tbl_p[r][i] - 1));
      end
    end
    // Only channel 1 is rewritten, the others keep their shadow settings
    tbl_wr[6] = 4'b0010;
    tbl_en[6] = 4'b1111;
    tbl_p[6][1] = 33;
    tbl_w[6][1] = 9;
  endtask

  task automatic drive_write(input cfg_field_e field, input int chan, input int data);
    @(posedge clk);
    #1;
    cfg_wr    = 1'b1;
    cfg_field = field;
    cfg_chan  = 2'(chan);
    cfg_data  = data;
  endtask

  task automatic apply_row(input int r);
    for (int i = 0; i < n_ch; i++) begin
      if (tbl_wr[r][i]) begin
        drive_write(field_period, i, tbl_p[r][i]);
        drive_write(field_width, i, tbl_w[r][i]);
        sh_p[i] = tbl_p[r][i];
        sh_w[i] = tbl_w[r][i];
        sh_written[i] = 1'b1;
      end
    end
    drive_write(field_enable, 0, int'(tbl_en[r]));
    // The monitor keeps the old expectations until it sees the commit
    @(posedge clk);
    #1;
    cfg_wr     = 1'b0;
    cfg_commit = 1'b1;
    for (int i = 0; i < n_ch; i++) begin
      act_p[i] = sh_written[i] ? sh_p[i] : def_period;
      act_w[i] = sh_w[i];
    end
    act_en = tbl_en[r];
    @(posedge clk);
    #1;
    cfg_commit = 1'b0;
    // Clear only after the restart has flushed the old pattern out of the output stage
    @(posedge clk);
    #1;
    cnt_clr = 1'b1;
    @(posedge clk);
    #1;
    cnt_clr = 1'b0;
  endtask

  task automatic run_window(input int r);
    repeat (window_len - n_ch) @(posedge clk);
    // Read back one edge counter per cycle at the end of the window
    for (int i = 0; i < n_ch; i++) begin
      @(posedge clk);
      #1;
      rd_chan = 2'(i);
      #1;
      check_value($sformatf("row %0d rd_count[%0d]", r, i), rd_count, edge_seen[i]);
      if (act_en[i]) begin
        check_value($sformatf("row %0d pulse_out[%0d] pulsing", r, i), edge_seen[i] >= 2, 1);
      end else begin
        check_value($sformatf("row %0d pulse_out[%0d] edges", r, i), edge_seen[i], 0);
      end
    end
  endtask

  // ************************************************************************
  // Pulse monitor
  // ************************************************************************

  // Predicts pulse_any from the active settings alone
  // Every enabled channel rises one cycle after arming and then repeats every P cycles
  function automatic logic predict_any();
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < n_ch; i++) begin
      if (act_en[i] && (since_arm >= 1) && (((since_arm - 1) % act_p[i]) < act_w[i])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Measures high runs and edge spacing of one armed channel
  // The first edge after a commit has no spacing and only checks phase alignment
  task automatic measure_channel(input int i);
    if (!act_en[i]) begin
      check_value($sformatf("pulse_out[%0d] while disabled", i), pulse_out[i], 0);
    end else if (rise_now[i]) begin
      if (have_rise[i]) begin
        check_value($sformatf("pulse_out[%0d] edge spacing", i), cyc - last_rise[i], act_p[i]);
      end else if (align_cyc < 0) begin
        align_cyc = cyc;
      end else begin
        check_value($sformatf("pulse_out[%0d] first edge cycle", i), cyc, align_cyc);
      end
      have_rise[i] = 1'b1;
      last_rise[i] = cyc;
      in_run[i]    = 1'b1;
      run_len[i]   = 1;
    end else if (in_run[i]) begin
      if (pulse_out[i]) begin
        run_len[i] = run_len[i] + 1;
      end else begin
        in_run[i] = 1'b0;
        check_value($sformatf("pulse_out[%0d] high run", i), run_len[i], act_w[i]);
      end
    end
  endtask

  // Samples on the falling edge where outputs and driven inputs are stable
  always @(negedge clk) begin
    if (rstn) begin
      cyc = cyc + 1;
      since_arm = since_arm + 1;
      rise_now = pulse_out & ~prev_out;
      if (!committed) begin
        check_value("pulse_out before first commit", pulse_out, 0);
        check_value("pulse_any before first commit", pulse_any, 0);
      end
      // Edge counts follow the collector rules, clear wins over an edge
      for (int i = 0; i < n_ch; i++) begin
        if (cnt_clr) begin
          edge_seen[i] = 0;
        end else if (rise_now[i] && (edge_seen[i] < 65535)) begin
          edge_seen[i] = edge_seen[i] + 1;
        end
      end
      // Commit lands at the next edge and restart one later, plus one output stage
      if (cfg_commit) begin
        committed = 1'b1;
        armed     = '0;
        holdoff   = 3;
        align_cyc = -1;
      end else if (holdoff > 0) begin
        holdoff = holdoff - 1;
        if (holdoff == 0) begin
          armed     = '1;
          in_run    = '0;
          have_rise = '0;
          since_arm = 0;
        end
      end
      // The old pattern still drains during the holdoff and is not predicted
      if (armed != '0) begin
        check_value("pulse_any", pulse_any, predict_any());
      end
      for (int i = 0; i < n_ch; i++) begin
        if (armed[i]) begin
          measure_channel(i);
        end
      end
      prev_out = pulse_out;
    end
  end

  // ************************************************************************
  // Main sequence
  // ************************************************************************

  initial begin
    seed        = 30;
    timeout_cnt = 0;
    rstn        = 1'b0;
    cfg_wr      = 1'b0;
    cfg_field   = field_period;
    cfg_chan    = '0;
    cfg_data    = '0;
    cfg_commit  = 1'b0;
    cnt_clr     = 1'b0;
    rd_chan     = '0;
    cyc         = 0;
    since_arm   = 0;
    holdoff     = 0;
    align_cyc   = -1;
    committed   = 1'b0;
    armed       = '0;
    prev_out    = '0;
    in_run      = '0;
    have_rise   = '0;
    sh_written  = '0;
    act_en      = '0;
    for (int i = 0; i < n_ch; i++) begin
      sh_p[i]      = 0;
      sh_w[i]      = def_width;
      act_p[i]     = def_period;
      act_w[i]     = def_width;
      run_len[i]   = 0;
      last_rise[i] = 0;
      edge_seen[i] = 0;
    end
    fill_table();
    repeat (10) @(posedge clk);
    #1;
    rstn = 1'b1;
    // The enable mask resets to zero so nothing may pulse or count yet
    for (int k = 0; k < idle_len; k++) begin
      @(posedge clk);
      #1;
      rd_chan = 2'(k % n_ch);
      #1;
      check_value("pulse_out after reset", pulse_out, 0);
      check_value("pulse_any after reset", pulse_any, 0);
      check_value($sformatf("rd_count[%0d] after reset", k % n_ch), rd_count, 0);
    end
    for (int r = 0; r < n_rows; r++) begin
      apply_row(r);
      run_window(r);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/pulse_gen_pkg.sv
src/pulse_cfg_regs.sv
src/pulse_channel.sv
src/pulse_collector.sv
src/pulse_gen_bank.sv
test/tb_pulse_gen_bank.sv

/* Bender.yml */
package:
  name: pulse_gen_bank

sources:
  - files:
      - src/pulse_gen_pkg.sv
      - src/pulse_cfg_regs.sv
      - src/pulse_channel.sv
      - src/pulse_collector.sv
      - src/pulse_gen_bank.sv
  - target: test
    files:
      - test/tb_pulse_gen_bank.sv
